// File: build.f
source/pool_pkg.sv
source/pool_line_ram.sv
source/pool_lane.sv
source/pool_sequencer.sv
source/pool_drain.sv
source/pool_layer_top.sv
test/pool_checker.sv
test/pool_props.sv
test/tb_pool.sv

// File: run.sh
#!/bin/sh
# build with verilator, run, then read the verdict back out of the log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_pool \
    -f build.f -o sim_pool > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_pool > sim.log 2>&1
cat sim.log
grep -q -e "Checks failed" -e "%Error" sim.log && exit 1
grep -q "All checks passed" sim.log || exit 1

// File: test/tb_pool.sv
`default_nettype none

module tb_pool;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IMG_ROWS    = 4;
    localparam int NUM_IMAGES  = 4;
    localparam int IMG_PIX     = IMG_ROWS * pool_pkg::IMG_WIDTH;
    localparam int NUM_PIX     = NUM_IMAGES * IMG_PIX;
    localparam int BANDS       = IMG_ROWS / pool_pkg::POOL_SIZE;
    localparam int NUM_OUT     = NUM_IMAGES * BANDS * pool_pkg::O_WIDTH;
    localparam int CYCLE_LIMIT = 20 * NUM_PIX;   // twenty cycles per input pixel
    localparam int VB          = pool_pkg::VALUE_BITS;
    localparam int EXP_BITS    = pool_pkg::CHANNELS * VB + 1;

    logic             clk = 1'b0;
    logic             reset = 1'b1;
    pool_pkg::pixel_t i_data [pool_pkg::CHANNELS];
    logic             i_valid = 1'b0;
    logic             i_last = 1'b0;
    logic             i_out_ready = 1'b0;
    logic             o_in_ready;
    pool_pkg::pixel_t o_data [pool_pkg::CHANNELS];
    logic             o_valid;
    logic             o_last;

    int               seed = 32'hf5e8;
    pool_pkg::pixel_t pix [NUM_PIX][pool_pkg::CHANNELS];  // whole stimulus drawn up front
    int               gap [NUM_PIX];                      // idle cycles before each pixel
    int               cycles = 0;
    int               tb_errors = 0;
    int               checked;
    int               errors;
    int               lasts;

    always #5 clk = ~clk;

    pool_layer_top dut_i (
        .clk (clk), .reset (reset), .i_data (i_data), .i_valid (i_valid), .i_last (i_last),
        .o_in_ready (o_in_ready), .o_data (o_data), .o_valid (o_valid), .o_last (o_last),
        .i_out_ready (i_out_ready)
    );

    pool_checker chk_i (
        .clk (clk), .reset (reset), .i_data (o_data), .i_valid (o_valid), .i_last (o_last),
        .i_ready (i_out_ready), .o_checked (checked), .o_errors (errors), .o_lasts (lasts)
    );

    bind pool_layer_top pool_props props_i (
        .clk (clk), .reset (reset), .i_in_ready (o_in_ready), .i_data (o_data),
        .i_valid (o_valid), .i_last (o_last), .i_out_ready (i_out_ready)
    );

    // random pixels with every third window all negative and the cropped column at full scale
    task draw_stimulus;
        logic [31:0] raw;
        int          idx;
        int          g;
        for (int img = 0; img < NUM_IMAGES; img++) begin
            for (int r = 0; r < IMG_ROWS; r++) begin
                for (int c = 0; c < pool_pkg::IMG_WIDTH; c++) begin
                    idx = img * IMG_PIX + r * pool_pkg::IMG_WIDTH + c;
                    for (int ch = 0; ch < pool_pkg::CHANNELS; ch++) begin
                        raw = $random(seed);
                        if (c >= pool_pkg::I_WIDTH) begin
                            pix[idx][ch] = 16'sh7fff;
                        end else if ((r / 2 + c / 2 + img) % 3 == 0) begin
                            pix[idx][ch] = raw[15:0] | 16'h8000;
                        end else begin
                            pix[idx][ch] = raw[15:0];
                        end
                    end
                    g = $random(seed) & 7;
                    gap[idx] = (g > 4) ? g - 4 : 0;   // mostly back to back
                end
            end
        end
    endtask

    // window max over the floor and the window pixels only
    task build_expected;
        logic [EXP_BITS-1:0] e;
        int                  m;
        int                  idx;
        for (int img = 0; img < NUM_IMAGES; img++) begin
            for (int b = 0; b < BANDS; b++) begin
                for (int o = 0; o < pool_pkg::O_WIDTH; o++) begin
                    for (int ch = 0; ch < pool_pkg::CHANNELS; ch++) begin
                        m = pool_pkg::RELU_EN ? 0 : -(2 ** (VB - 1));
                        for (int dr = 0; dr < pool_pkg::POOL_SIZE; dr++) begin
                            for (int dc = 0; dc < pool_pkg::POOL_SIZE; dc++) begin
                                idx = img * IMG_PIX + (b * pool_pkg::POOL_SIZE + dr) *
                                      pool_pkg::IMG_WIDTH + o * pool_pkg::POOL_SIZE + dc;
                                if (int'(pix[idx][ch]) > m) m = int'(pix[idx][ch]);
                            end
                        end
                        e[ch*VB +: VB] = m[VB-1:0];
                    end
                    e[EXP_BITS-1] = (b == BANDS - 1) && (o == pool_pkg::O_WIDTH - 1);
                    chk_i.push_expected(e);
                end
            end
        end
    endtask

    task automatic send_pixel(input int idx);
        logic taken;
        repeat (gap[idx]) begin
            @(posedge clk);
            #1;
        end
        for (int ch = 0; ch < pool_pkg::CHANNELS; ch++) i_data[ch] = pix[idx][ch];
        i_valid = 1'b1;
        i_last  = (idx % IMG_PIX) == (IMG_PIX - 1);   // final pixel of the image
        taken   = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = o_in_ready;   // registered so the next edge sees this value
            @(posedge clk);
            #1;
        end
        i_valid = 1'b0;
        i_last  = 1'b0;
    endtask

    always @(posedge clk) begin   // random back-pressure with ready about two beats in three
        #1;
        i_out_ready = ($random(seed) % 3) != 0;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: only %0d of %0d outputs after %0d cycles",
                     checked, NUM_OUT, cycles);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        for (int ch = 0; ch < pool_pkg::CHANNELS; ch++) i_data[ch] = '0;
        draw_stimulus();
        build_expected();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int p = 0; p < NUM_PIX; p++) send_pixel(p);
        while (checked < NUM_OUT) @(posedge clk);
        repeat (20) @(posedge clk);   // room for any stray extra beat
        if (lasts != NUM_IMAGES) begin
            $display("Fail last_flag_count: expected %0d, actual %0d", NUM_IMAGES, lasts);
            tb_errors++;
        end
        $display("summary: %0d outputs checked, %0d last flags, %0d errors",
                 checked, lasts, errors + tb_errors);
        if (errors + tb_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/pool_props.sv
`default_nettype none

// output handshake and reset rules checked inside pool_layer_top
module pool_props (
    input wire logic             clk,
    input wire logic             reset,
    input wire logic             i_in_ready,
    input wire pool_pkg::pixel_t i_data [pool_pkg::CHANNELS],
    input wire logic             i_valid,
    input wire logic             i_last,
    input wire logic             i_out_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [pool_pkg::CHANNELS*pool_pkg::VALUE_BITS-1:0] data_flat;  // all lanes side by side

    always_comb begin
        for (int c = 0; c < pool_pkg::CHANNELS; c++) begin
            data_flat[c*pool_pkg::VALUE_BITS +: pool_pkg::VALUE_BITS] = i_data[c];
        end
    end

    // first edge with reset low still shows the reset values
    reset_idle: assert property (@(posedge clk)
        $fell(reset) |-> !i_in_ready && !i_valid && !i_last)
        else $error("ready, valid or last high right after reset");

    // stalled beat must not change
    stall_hold: assert property (@(posedge clk) disable iff (reset)
        i_valid && !i_out_ready |=> i_valid && $stable(data_flat) && $stable(i_last))
        else $error("output beat changed while stalled");

    // fill and drain take turns on the line ram
    no_overlap: assert property (@(posedge clk) disable iff (reset) !(i_in_ready && i_valid))
        else $error("input ready while output valid");

endmodule

`default_nettype wire

// File: test/pool_checker.sv
`default_nettype none

// scoreboard on the output stream, expected beats pushed by the model in tb_pool
module pool_checker (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire pool_pkg::pixel_t i_data [pool_pkg::CHANNELS],
    input  wire logic             i_valid,
    input  wire logic             i_last,
    input  wire logic             i_ready,
    output int                    o_checked,   // beats compared so far
    output int                    o_errors,
    output int                    o_lasts      // o_last flags seen on transfers
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int VB       = pool_pkg::VALUE_BITS;
    localparam int EXP_BITS = pool_pkg::CHANNELS * VB + 1;  // last flag on top

    logic [EXP_BITS-1:0] exp_q [$];
    int checked_cnt = 0;
    int err_cnt     = 0;
    int last_cnt    = 0;
    int image_idx   = 0;
    int out_idx     = 0;   // output beat within the current image
    int image_errs  = 0;

    assign o_checked = checked_cnt;
    assign o_errors  = err_cnt;
    assign o_lasts   = last_cnt;

    task push_expected(input logic [EXP_BITS-1:0] e);
        exp_q.push_back(e);
    endtask

    // negedge, so valid, ready and data are settled for the coming edge
    always @(negedge clk) begin : check_beat
        logic [EXP_BITS-1:0] e;
        pool_pkg::pixel_t    exp_v;
        if (!reset && i_valid && i_ready) begin
            if (exp_q.size() == 0) begin
                $display("output beat arrived with no expected value left");
                err_cnt++;
            end else begin
                e = exp_q.pop_front();
                for (int c = 0; c < pool_pkg::CHANNELS; c++) begin
                    exp_v = pool_pkg::pixel_t'(e[c*VB +: VB]);
                    if (i_data[c] !== exp_v) begin
                        $display("Fail image%0d_out%0d_ch%0d: expected %0d, actual %0d",
                                 image_idx, out_idx, c, exp_v, i_data[c]);
                        err_cnt++;
                        image_errs++;
                    end
                end
                if (i_last !== e[EXP_BITS-1]) begin
                    $display("Fail image%0d_out%0d_last: expected %0b, actual %0b",
                             image_idx, out_idx, e[EXP_BITS-1], i_last);
                    err_cnt++;
                    image_errs++;
                end
                checked_cnt++;
                out_idx++;
                if (e[EXP_BITS-1]) begin   // image complete, one line for it
                    $display("image%0d finished: %0d outputs, %0d mismatches",
                             image_idx, out_idx, image_errs);
                    image_idx++;
                    out_idx    = 0;
                    image_errs = 0;
                end
            end
            if (i_last) last_cnt++;
        end
    end

endmodule

`default_nettype wire

// File: source/pool_layer_top.sv
`default_nettype none

// max pooling over all channels, one sequencer, one lane per channel, one drain
module pool_layer_top (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire pool_pkg::pixel_t i_data [pool_pkg::CHANNELS],
    input  wire logic             i_valid,
    input  wire logic             i_last,
    output logic                  o_in_ready,
    output pool_pkg::pixel_t      o_data [pool_pkg::CHANNELS],
    output logic                  o_valid,
    output logic                  o_last,
    input  wire logic             i_out_ready
);

    logic                load_floor;
    logic                load_ram;
    logic                take;
    logic                we;
    pool_pkg::col_addr_t wr_addr;
    pool_pkg::col_addr_t fill_rd_addr;  // sequencer's read address
    pool_pkg::col_addr_t rd_addr;       // what the lanes actually see
    logic                rows_done;
    logic                image_end;
    logic                drain_done;
    pool_pkg::pixel_t    lane_data [pool_pkg::CHANNELS];

    pool_sequencer u_sequencer (
        .clk            (clk),
        .reset          (reset),
        .i_valid        (i_valid),
        .i_last         (i_last),
        .i_drain_done   (drain_done),
        .o_in_ready     (o_in_ready),
        .o_load_floor   (load_floor),
        .o_load_ram     (load_ram),
        .o_take         (take),
        .o_we           (we),
        .o_wr_addr      (wr_addr),
        .o_fill_rd_addr (fill_rd_addr),
        .o_rows_done    (rows_done),
        .o_image_end    (image_end)
    );

    // controls broadcast, pixel split per channel
    for (genvar c = 0; c < pool_pkg::CHANNELS; c++) begin : g_lane
        pool_lane u_lane (
            .clk          (clk),
            .i_pixel      (i_data[c]),
            .i_load_floor (load_floor),
            .i_load_ram   (load_ram),
            .i_take       (take),
            .i_we         (we),
            .i_wr_addr    (wr_addr),
            .i_rd_addr    (rd_addr),
            .o_rd_data    (lane_data[c])
        );
    end

    pool_drain u_drain (
        .clk            (clk),
        .reset          (reset),
        .i_rows_done    (rows_done),
        .i_image_end    (image_end),
        .i_fill_rd_addr (fill_rd_addr),
        .i_lane_data    (lane_data),
        .i_out_ready    (i_out_ready),
        .o_rd_addr      (rd_addr),
        .o_data         (o_data),
        .o_valid        (o_valid),
        .o_last         (o_last),
        .o_drain_done   (drain_done)
    );

endmodule

`default_nettype wire

// File: source/pool_drain.sv
`default_nettype none

// output side, reads one finished row out of every lane
module pool_drain (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire logic                i_rows_done,
    input  wire logic                i_image_end,     // band holds the image's last pixel
    input  wire pool_pkg::col_addr_t i_fill_rd_addr,
    input  wire pool_pkg::pixel_t    i_lane_data [pool_pkg::CHANNELS],
    input  wire logic                i_out_ready,
    output pool_pkg::col_addr_t      o_rd_addr,       // applied to every lane ram
    output pool_pkg::pixel_t         o_data [pool_pkg::CHANNELS],
    output logic                     o_valid,
    output logic                     o_last,
    output logic                     o_drain_done
);

    pool_pkg::drain_state_t state_q;
    pool_pkg::drain_state_t state_n;
    pool_pkg::col_addr_t    addr_q;    // address the ram registered last edge
    logic                   last_col;
    logic                   xfer;
    logic                   done_n;

    assign o_valid  = (state_q == pool_pkg::st_show);
    assign xfer     = o_valid && i_out_ready;
    assign last_col = (addr_q == pool_pkg::col_addr_t'(pool_pkg::O_WIDTH - 1));
    assign o_last   = o_valid && last_col && i_image_end;

    always_comb begin
        state_n   = state_q;
        o_rd_addr = addr_q;   // hold, so ram output stays put under back-pressure
        done_n    = 1'b0;

        case (state_q)
            pool_pkg::st_idle: begin
                if (i_rows_done) begin
                    o_rd_addr = '0;
                    state_n   = pool_pkg::st_prime;
                end else begin
                    o_rd_addr = i_fill_rd_addr;   // sequencer owns the ram
                end
            end
            pool_pkg::st_prime: begin
                state_n = pool_pkg::st_show;      // word 0 lands on the ram output
            end
            pool_pkg::st_show: begin
                if (xfer) begin
                    if (last_col) begin
                        o_rd_addr = '0;
                        state_n   = pool_pkg::st_idle;
                        done_n    = 1'b1;
                    end else begin
                        o_rd_addr = addr_q + 1'b1;
                    end
                end
            end
            default: begin
                state_n = pool_pkg::st_idle;
            end
        endcase
    end

    // data only shown while valid
    always_comb begin
        for (int c = 0; c < pool_pkg::CHANNELS; c++) begin
            o_data[c] = o_valid ? i_lane_data[c] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q      <= pool_pkg::st_idle;
            addr_q       <= '0;
            o_drain_done <= 1'b0;
        end else begin
            state_q      <= state_n;
            addr_q       <= o_rd_addr;
            o_drain_done <= done_n;   // one cycle after the final transfer
        end
    end

endmodule

`default_nettype wire

// File: source/pool_sequencer.sv
`default_nettype none

// input side control, shared by all lanes
module pool_sequencer (
    input  wire logic           clk,
    input  wire logic           reset,
    input  wire logic           i_valid,
    input  wire logic           i_last,
    input  wire logic           i_drain_done,
    output logic                o_in_ready,     // registered level
    output logic                o_load_floor,
    output logic                o_load_ram,
    output logic                o_take,
    output logic                o_we,
    output pool_pkg::col_addr_t o_wr_addr,
    output pool_pkg::col_addr_t o_fill_rd_addr,
    output logic                o_rows_done,    // one cycle, band ready for drain
    output logic                o_image_end     // held until the drain is done
);

    pool_pkg::seq_state_t state_q;
    pool_pkg::seq_state_t state_n;
    pool_pkg::in_col_t    col_q;    // input pixels accepted in this row
    pool_pkg::in_col_t    col_n;
    pool_pkg::col_addr_t  addr_q;   // current output column
    pool_pkg::col_addr_t  addr_n;
    pool_pkg::win_cnt_t   win_q;    // pixels of this window in this row
    pool_pkg::win_cnt_t   win_n;
    pool_pkg::win_cnt_t   row_q;    // row within the band
    pool_pkg::win_cnt_t   row_n;
    logic                 in_ready_n;
    logic                 image_end_n;
    logic                 rows_done_n;
    logic                 accept;   // pixel transfer this cycle
    logic                 row_end;  // last pixel of the row is in

    assign accept = o_in_ready && i_valid;

    // same column for both, read in fetch, written in commit
    assign o_wr_addr      = addr_q;
    assign o_fill_rd_addr = addr_q;

    assign o_load_floor = (state_q == pool_pkg::st_load) && (row_q == '0);
    assign o_load_ram   = (state_q == pool_pkg::st_load) && (row_q != '0);
    assign o_take       = (state_q == pool_pkg::st_collect) && accept;
    assign o_we         = (state_q == pool_pkg::st_commit);

    always_comb begin
        state_n     = state_q;
        col_n       = col_q;
        addr_n      = addr_q;
        win_n       = win_q;
        row_n       = row_q;
        in_ready_n  = o_in_ready;
        image_end_n = o_image_end;
        rows_done_n = 1'b0;
        row_end     = 1'b0;

        // column count covers window and cropped pixels alike
        if (accept) begin
            col_n = col_q + 1'b1;
            if (i_last) begin
                image_end_n = 1'b1;
            end
        end

        case (state_q)
            pool_pkg::st_fetch: begin
                state_n = pool_pkg::st_load;   // ram data shows next cycle
            end
            pool_pkg::st_load: begin
                state_n    = pool_pkg::st_collect;
                in_ready_n = 1'b1;
            end
            pool_pkg::st_collect: begin
                if (accept) begin
                    win_n = win_q + 1'b1;
                    if (win_q == pool_pkg::win_cnt_t'(pool_pkg::POOL_SIZE - 1)) begin
                        state_n = pool_pkg::st_commit;
                        win_n   = '0;
                        // stay ready only if cropped columns come right after
                        in_ready_n = (pool_pkg::I_WIDTH != pool_pkg::IMG_WIDTH) &&
                                     (col_n == pool_pkg::in_col_t'(pool_pkg::I_WIDTH));
                    end
                end
            end
            pool_pkg::st_commit: begin
                if (col_q < pool_pkg::in_col_t'(pool_pkg::I_WIDTH)) begin
                    addr_n  = addr_q + 1'b1;   // next window of this row
                    state_n = pool_pkg::st_fetch;
                end else if (col_n == pool_pkg::in_col_t'(pool_pkg::IMG_WIDTH)) begin
                    row_end = 1'b1;            // no crop, or crop already taken here
                end else begin
                    state_n = pool_pkg::st_skip;
                end
            end
            pool_pkg::st_skip: begin
                if (col_n == pool_pkg::in_col_t'(pool_pkg::IMG_WIDTH)) begin
                    row_end = 1'b1;
                end
            end
            pool_pkg::st_wait: begin
                if (i_drain_done) begin
                    state_n     = pool_pkg::st_fetch;
                    image_end_n = 1'b0;
                end
            end
            default: begin
                state_n = pool_pkg::st_fetch;
            end
        endcase

        if (row_end) begin
            col_n      = '0;
            addr_n     = '0;
            in_ready_n = 1'b0;
            if (row_q == pool_pkg::win_cnt_t'(pool_pkg::POOL_SIZE - 1)) begin
                row_n       = '0;
                rows_done_n = 1'b1;           // hand the ram to the drain
                state_n     = pool_pkg::st_wait;
            end else begin
                row_n   = row_q + 1'b1;
                state_n = pool_pkg::st_fetch;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q     <= pool_pkg::st_fetch;
            col_q       <= '0;
            addr_q      <= '0;
            win_q       <= '0;
            row_q       <= '0;
            o_in_ready  <= 1'b0;
            o_image_end <= 1'b0;
            o_rows_done <= 1'b0;
        end else begin
            state_q     <= state_n;
            col_q       <= col_n;
            addr_q      <= addr_n;
            win_q       <= win_n;
            row_q       <= row_n;
            o_in_ready  <= in_ready_n;
            o_image_end <= image_end_n;
            o_rows_done <= rows_done_n;
        end
    end

endmodule

`default_nettype wire

// File: source/pool_lane.sv
`default_nettype none

// one channel: running window max and the line ram behind it
module pool_lane (
    input  wire logic                clk,
    input  wire pool_pkg::pixel_t    i_pixel,       // this channel's share of the input pixel
    input  wire logic                i_load_floor,  // first row of a band
    input  wire logic                i_load_ram,    // later rows resume the stored max
    input  wire logic                i_take,        // pixel accepted inside a window
    input  wire logic                i_we,
    input  wire pool_pkg::col_addr_t i_wr_addr,
    input  wire pool_pkg::col_addr_t i_rd_addr,     // fill or drain address, muxed upstream
    output pool_pkg::pixel_t         o_rd_data
);

    // relu clamps at zero, otherwise start from the most negative value
    localparam pool_pkg::pixel_t FLOOR_VAL = pool_pkg::RELU_EN ? '0 :
        {1'b1, {(pool_pkg::VALUE_BITS-1){1'b0}}};

    pool_pkg::pixel_t run_max;   // max over the window so far, all rows of the band
    pool_pkg::pixel_t ram_data;

    always_ff @(posedge clk) begin
        if (i_load_floor) begin
            run_max <= FLOOR_VAL;
        end else if (i_load_ram) begin
            run_max <= ram_data;                           // read issued during fetch
        end else if (i_take && (i_pixel > run_max)) begin  // signed compare
            run_max <= i_pixel;
        end
    end

    pool_line_ram u_line_ram (
        .clk       (clk),
        .i_we      (i_we),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (run_max),   // final after the last take, written on commit
        .i_rd_addr (i_rd_addr),
        .o_rd_data (ram_data)
    );

    assign o_rd_data = ram_data;  // drain reads the same port once the band is done

endmodule

`default_nettype wire

// File: source/pool_line_ram.sv
`default_nettype none

// partial maxima of one output row, one word per output column
module pool_line_ram (
    input  wire logic                clk,
    input  wire logic                i_we,       // commit of a window
    input  wire pool_pkg::col_addr_t i_wr_addr,
    input  wire pool_pkg::pixel_t    i_wr_data,
    input  wire pool_pkg::col_addr_t i_rd_addr,
    output pool_pkg::pixel_t         o_rd_data   // valid one cycle after the address
);

    pool_pkg::pixel_t mem [pool_pkg::O_WIDTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_wr_addr] <= i_wr_data;
        end
        o_rd_data <= mem[i_rd_addr];  // sync read, maps onto block ram
    end

endmodule

`default_nettype wire

// File: source/pool_pkg.sv
`default_nettype none

package pool_pkg;

    // stream and window geometry
    localparam int VALUE_BITS = 16;                     // bits per channel value
    localparam int CHANNELS   = 3;                      // lanes moving in lockstep
    localparam int POOL_SIZE  = 2;                      // window edge, rows and columns
    localparam int IMG_WIDTH  = 11;                     // input pixels per row
    localparam int O_WIDTH    = IMG_WIDTH / POOL_SIZE;  // whole windows per row
    localparam int I_WIDTH    = O_WIDTH * POOL_SIZE;    // columns that reach a window

    // 1 clamps every window at zero, 0 starts from the most negative value
    localparam bit RELU_EN = 1'b1;

    typedef logic signed [VALUE_BITS-1:0] pixel_t;

    typedef logic [$clog2(O_WIDTH+1)-1:0]   col_addr_t;  // line ram word, one per output column
    typedef logic [$clog2(IMG_WIDTH+1)-1:0] in_col_t;    // counts up to a full input row
    typedef logic [$clog2(POOL_SIZE+1)-1:0] win_cnt_t;   // pixels in a window, rows in a band

    // input side, one pass per window
    typedef enum logic [2:0] {
        st_fetch,    // column address on the ram
        st_load,     // running max seeded from floor or ram
        st_collect,  // taking the window's pixels of this row
        st_commit,   // max written back
        st_skip,     // swallowing cropped columns
        st_wait      // band complete, drain owns the ram
    } seq_state_t;

    // output side
    typedef enum logic [1:0] {
        st_idle,
        st_prime,
        st_show
    } drain_state_t;

endpackage

`default_nettype wire
